// File: source/reconfig_regs_pkg.sv
/* register map of the transceiver reconfiguration controller analog window
   imported by the encoder, the write sequencer and the top level for addresses and codes */
`default_nettype none

package reconfig_regs_pkg;

   // management bus widths
   localparam int AV_ADDR_WIDTH = 32;   // the controller decodes only the low bits
   localparam int AV_DATA_WIDTH = 32;

   // analog register window
   localparam logic [AV_ADDR_WIDTH-1:0] ADDR_XR_ANALOG_LCH    = 32'd8;   // logical channel select
   localparam logic [AV_ADDR_WIDTH-1:0] ADDR_XR_ANALOG_STATUS = 32'd10;  // control and status
   localparam logic [AV_ADDR_WIDTH-1:0] ADDR_XR_ANALOG_OFFSET = 32'd11;  // selects the analog setting
   localparam logic [AV_ADDR_WIDTH-1:0] ADDR_XR_ANALOG_DATA   = 32'd12;  // value of that setting

   // writing this to the status register launches the analog write
   localparam logic [AV_DATA_WIDTH-1:0] STATUS_CMD_WRITE = 32'd1;

   /* offsets inside the analog window
      note that the pre-tap sits below the post-tap in the controller map */
   localparam logic [AV_DATA_WIDTH-1:0] OFFSET_VOD  = 32'd0;   // main tap output swing
   localparam logic [AV_DATA_WIDTH-1:0] OFFSET_PRE  = 32'd1;   // first pre-emphasis pre-tap
   localparam logic [AV_DATA_WIDTH-1:0] OFFSET_POST = 32'd2;   // first pre-emphasis post-tap

endpackage

`default_nettype wire

// File: source/pma_tap_pkg.sv
/* tap and sequencer definitions shared by the analog settings updater
   imported by the queue, the encoder, the sequencer and the testbench properties */
`default_nettype none

package pma_tap_pkg;

   // tap value widths as they arrive from link training
   localparam int MAIN_TAP_WIDTH = 6;   // VOD setting
   localparam int POST_TAP_WIDTH = 5;   // first post-tap magnitude
   localparam int PRE_TAP_WIDTH  = 4;   // first pre-tap magnitude before negation
   localparam int TAP_COUNT      = 3;   // main, post and pre

   /* the pending mask tap_to_upd has main on bit 2, post on bit 1 and pre on bit 0
      taps are serviced from the highest set bit down */

   // names the tap currently being written to the controller
   typedef enum logic [1:0] {
      TAP_MAIN = 2'd0,   // VOD
      TAP_POST = 2'd1,
      TAP_PRE  = 2'd2
   } tap_t;

   // write sequencer states where each write state matches the register on the bus
   typedef enum logic [2:0] {
      SEQ_IDLE      = 3'd0,   // no tap in progress
      SEQ_WR_LCH    = 3'd1,   // logical channel write on the bus
      SEQ_WR_OFFSET = 3'd2,   // offset write on the bus
      SEQ_WR_DATA   = 3'd3,   // tap data write on the bus
      SEQ_WR_STATUS = 3'd4,   // write command on the bus
      SEQ_WAIT_RISE = 3'd5,   // controller has not yet started
      SEQ_WAIT_FALL = 3'd6    // controller is busy with the tap
   } seq_state_t;

endpackage

`default_nettype wire

// File: source/tap_request_queue.sv
/* holds the taps of an accepted link training request
   presents one pending tap at a time to the write sequencer, main first and pre last */
`default_nettype none

module tap_request_queue (
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              lt_start,     // update request level
   input  wire                              mgmt_busy,    // controller busy level
   input  wire [pma_tap_pkg::TAP_COUNT-1:0] tap_to_upd,   // taps named by the request
   input  wire                              tap_done,     // active tap has been written
   output logic                             tap_valid,
   output pma_tap_pkg::tap_t                active_tap,
   output logic                             rc_busy
);
   import pma_tap_pkg::*;

   logic [TAP_COUNT-1:0] pending;        // taps still to be written
   logic [TAP_COUNT-1:0] pending_next;
   logic [TAP_COUNT-1:0] active_bit;     // one hot form of active_tap
   logic                 accept;

   // a request is taken only when the queue is empty and the controller is idle
   assign accept = lt_start && !mgmt_busy && (|tap_to_upd) && !(|pending);

   // priority select of the next tap
   always_comb begin
      if (pending[2]) begin
         active_tap = TAP_MAIN;           // VOD always goes first
         active_bit = 3'b100;
      end else if (pending[1]) begin
         active_tap = TAP_POST;
         active_bit = 3'b010;
      end else if (pending[0]) begin
         active_tap = TAP_PRE;
         active_bit = 3'b001;
      end else begin
         active_tap = TAP_MAIN;           // don't care while tap_valid is low
         active_bit = 3'b000;
      end
   end

   always_comb begin
      pending_next = pending;
      if (accept)
         pending_next = tap_to_upd;       // the mask is frozen for the whole request
      else if (tap_done)
         pending_next = pending & ~active_bit;  // retire the tap just written
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pending <= '0;
         rc_busy <= 1'b0;
      end else begin
         pending <= pending_next;
         rc_busy <= |pending_next;        // falls on the same edge the last tap retires
      end
   end

   assign tap_valid = |pending;          // a tap is waiting or in progress

endmodule

`default_nettype wire

// File: source/tap_word_encoder.sv
/* forms the offset and data words for the tap being written
   purely combinational so the sequencer sees the words in the same cycle as active_tap */
`default_nettype none

module tap_word_encoder (
   input  wire pma_tap_pkg::tap_t                      active_tap,
   input  wire [pma_tap_pkg::MAIN_TAP_WIDTH-1:0]       main_tap,
   input  wire [pma_tap_pkg::POST_TAP_WIDTH-1:0]       post_tap,
   input  wire [pma_tap_pkg::PRE_TAP_WIDTH-1:0]        pre_tap,
   output logic [reconfig_regs_pkg::AV_DATA_WIDTH-1:0] tap_offset,
   output logic [reconfig_regs_pkg::AV_DATA_WIDTH-1:0] tap_data
);
   import reconfig_regs_pkg::*;
   import pma_tap_pkg::*;

   logic [PRE_TAP_WIDTH-1:0]  pre_tap_enc;   // negated pre-tap
   logic [AV_DATA_WIDTH-1:0]  main_word;
   logic [AV_DATA_WIDTH-1:0]  post_word;
   logic [AV_DATA_WIDTH-1:0]  pre_word;

   /* the controller expects the pre-tap as a negative two's complement value
      zero stays zero and any other v becomes 16 minus v */
   assign pre_tap_enc = -pre_tap;

   // tap values are unsigned and go out zero extended
   assign main_word = {{(AV_DATA_WIDTH-MAIN_TAP_WIDTH){1'b0}}, main_tap};
   assign post_word = {{(AV_DATA_WIDTH-POST_TAP_WIDTH){1'b0}}, post_tap};
   assign pre_word  = {{(AV_DATA_WIDTH-PRE_TAP_WIDTH){1'b0}}, pre_tap_enc};

   always_comb begin
      case (active_tap)
         TAP_MAIN: begin
            tap_offset = OFFSET_VOD;      // VOD setting
            tap_data   = main_word;
         end
         TAP_POST: begin
            tap_offset = OFFSET_POST;
            tap_data   = post_word;
         end
         TAP_PRE: begin
            tap_offset = OFFSET_PRE;
            tap_data   = pre_word;        // sent in negated form
         end
         default: begin
            tap_offset = OFFSET_VOD;      // unused encoding of tap_t
            tap_data   = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/analog_write_sequencer.sv
/* writes one tap into the controller analog window as four back to back register writes
   then waits for the controller busy pulse and reports the tap as done */
`default_nettype none

module analog_write_sequencer (
   input  wire                                          clk,
   input  wire                                          reset,
   input  wire                                          tap_valid,        // a tap is pending
   input  wire                                          mgmt_busy,        // controller busy level
   input  wire  [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  logical_channel,
   input  wire  [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  tap_offset,
   input  wire  [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  tap_data,
   output logic                                         av_write,
   output logic [reconfig_regs_pkg::AV_ADDR_WIDTH-1:0]  av_address,
   output logic [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  av_writedata,
   output logic                                         tap_done
);
   import reconfig_regs_pkg::*;
   import pma_tap_pkg::*;

   seq_state_t               state;
   seq_state_t               state_next;
   logic                     write_next;      // bus values for the next cycle
   logic [AV_ADDR_WIDTH-1:0] address_next;
   logic [AV_DATA_WIDTH-1:0] writedata_next;

   // one cycle pulse once the controller has finished with the tap
   assign tap_done = (state == SEQ_WAIT_FALL) && !mgmt_busy;

   always_comb begin
      state_next     = state;
      write_next     = 1'b0;
      address_next   = av_address;            // hold the last write when the bus is idle
      writedata_next = av_writedata;
      case (state)
         SEQ_IDLE: begin
            if (tap_valid) begin
               state_next     = SEQ_WR_LCH;
               write_next     = 1'b1;
               address_next   = ADDR_XR_ANALOG_LCH;
               writedata_next = logical_channel;   // select the channel first
            end
         end
         SEQ_WR_LCH: begin
            state_next     = SEQ_WR_OFFSET;
            write_next     = 1'b1;
            address_next   = ADDR_XR_ANALOG_OFFSET;
            writedata_next = tap_offset;           // which analog setting to change
         end
         SEQ_WR_OFFSET: begin
            state_next     = SEQ_WR_DATA;
            write_next     = 1'b1;
            address_next   = ADDR_XR_ANALOG_DATA;
            writedata_next = tap_data;
         end
         SEQ_WR_DATA: begin
            state_next     = SEQ_WR_STATUS;
            write_next     = 1'b1;
            address_next   = ADDR_XR_ANALOG_STATUS;
            writedata_next = STATUS_CMD_WRITE;     // kicks off the analog write
         end
         SEQ_WR_STATUS: begin
            state_next = SEQ_WAIT_RISE;            // the command is on the bus this cycle
         end
         SEQ_WAIT_RISE: begin
            if (mgmt_busy)
               state_next = SEQ_WAIT_FALL;         // controller has picked up the command
         end
         SEQ_WAIT_FALL: begin
            if (!mgmt_busy)
               state_next = SEQ_IDLE;              // tap is in the transceiver now
         end
         default: begin
            state_next = SEQ_IDLE;                 // unused encoding recovers to idle
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state        <= SEQ_IDLE;
         av_write     <= 1'b0;
         av_address   <= '0;
         av_writedata <= '0;
      end else begin
         state        <= state_next;
         av_write     <= write_next;          // registered so the strobe is glitch free
         av_address   <= address_next;
         av_writedata <= writedata_next;
      end
   end

endmodule

`default_nettype wire

// File: source/pma_reconfig_top.sv
/* transceiver analog settings updater for link training
   turns a tap update request into register writes to the reconfiguration controller */
`default_nettype none

module pma_reconfig_top (
   input  wire                                          clk,
   input  wire                                          reset,
   input  wire                                          lt_start,
   input  wire                                          mgmt_busy,
   input  wire  [pma_tap_pkg::TAP_COUNT-1:0]            tap_to_upd,
   input  wire  [pma_tap_pkg::MAIN_TAP_WIDTH-1:0]       main_tap,
   input  wire  [pma_tap_pkg::POST_TAP_WIDTH-1:0]       post_tap,
   input  wire  [pma_tap_pkg::PRE_TAP_WIDTH-1:0]        pre_tap,
   input  wire  [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  logical_channel,
   output logic                                         av_write,
   output logic [reconfig_regs_pkg::AV_ADDR_WIDTH-1:0]  av_address,
   output logic [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  av_writedata,
   output logic                                         rc_busy
);
   import reconfig_regs_pkg::*;
   import pma_tap_pkg::*;

   logic                     tap_valid;    // queue holds a tap
   tap_t                     active_tap;   // tap being written
   logic [AV_DATA_WIDTH-1:0] tap_offset;
   logic [AV_DATA_WIDTH-1:0] tap_data;
   logic                     tap_done;     // sequencer finished the active tap

   tap_request_queue i_queue (
      .clk        (clk),
      .reset      (reset),
      .lt_start   (lt_start),
      .mgmt_busy  (mgmt_busy),
      .tap_to_upd (tap_to_upd),
      .tap_done   (tap_done),
      .tap_valid  (tap_valid),
      .active_tap (active_tap),
      .rc_busy    (rc_busy)
   );

   tap_word_encoder i_encoder (
      .active_tap (active_tap),
      .main_tap   (main_tap),
      .post_tap   (post_tap),
      .pre_tap    (pre_tap),
      .tap_offset (tap_offset),
      .tap_data   (tap_data)
   );

   analog_write_sequencer i_sequencer (
      .clk             (clk),
      .reset           (reset),
      .tap_valid       (tap_valid),
      .mgmt_busy       (mgmt_busy),
      .logical_channel (logical_channel),
      .tap_offset      (tap_offset),
      .tap_data        (tap_data),
      .av_write        (av_write),
      .av_address      (av_address),
      .av_writedata    (av_writedata),
      .tap_done        (tap_done)
   );

endmodule

`default_nettype wire

// File: testbench/pma_reconfig_checker.sv
/* scoreboard of the analog settings updater
   rebuilds the register writes of each accepted request and checks bus values and timing */
`default_nettype none

module pma_reconfig_checker (
   input  wire                                         clk,
   input  wire                                         reset,
   input  wire                                         lt_start,
   input  wire                                         mgmt_busy,
   input  wire [pma_tap_pkg::TAP_COUNT-1:0]            tap_to_upd,
   input  wire [pma_tap_pkg::MAIN_TAP_WIDTH-1:0]       main_tap,
   input  wire [pma_tap_pkg::POST_TAP_WIDTH-1:0]       post_tap,
   input  wire [pma_tap_pkg::PRE_TAP_WIDTH-1:0]        pre_tap,
   input  wire [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  logical_channel,
   input  wire                                         av_write,
   input  wire [reconfig_regs_pkg::AV_ADDR_WIDTH-1:0]  av_address,
   input  wire [reconfig_regs_pkg::AV_DATA_WIDTH-1:0]  av_writedata,
   input  wire                                         rc_busy,
   output int                                          error_count,
   output int                                          write_count,
   output int                                          request_count
);
   timeunit 1ns;
   timeprecision 100ps;
   import reconfig_regs_pkg::*;
   import pma_tap_pkg::*;

   logic [63:0] exp_q[$];            // expected address and data in bus order
   logic [63:0] exp_word;
   logic        reset_q;             // inputs as the DUT saw them at the last rising edge
   logic        busy_q;
   logic        start_ok_q;
   logic        rc_busy_prev = 1'b0;
   logic        first_write = 1'b0;
   int          cycle = 0;
   int          rise_cycle = 0;
   int          fall_cycle = 0;
   int          last_write_cycle = 0;
   int          group_pos = 0;       // place of the next write inside its tap
   int          pulse_phase = 0;     // 0 none, 1 wait busy high, 2 wait busy low, 3 pulse over
   int          errors = 0;
   int          writes = 0;
   int          requests = 0;

   assign error_count   = errors;
   assign write_count   = writes;
   assign request_count = requests;

   function automatic void push_tap(input logic [31:0] chan, input logic [31:0] offset,
                                    input logic [31:0] value);
      exp_q.push_back({ADDR_XR_ANALOG_LCH, chan});
      exp_q.push_back({ADDR_XR_ANALOG_OFFSET, offset});
      exp_q.push_back({ADDR_XR_ANALOG_DATA, value});
      exp_q.push_back({ADDR_XR_ANALOG_STATUS, 32'd1});   // write command
   endfunction

   // reference model that lists the writes of a request in the order main, post, pre
   function automatic void expected_writes(input logic [2:0] mask, input logic [5:0] main_v,
                                           input logic [4:0] post_v, input logic [3:0] pre_v,
                                           input logic [31:0] chan);
      logic [31:0] pre_word;
      pre_word = (pre_v == 4'd0) ? 32'd0 : 32'd16 - {28'd0, pre_v};   // negated pre-tap
      if (mask[2])
         push_tap(chan, 32'd0, {26'd0, main_v});
      if (mask[1])
         push_tap(chan, 32'd2, {27'd0, post_v});
      if (mask[0])
         push_tap(chan, 32'd1, pre_word);
   endfunction

   task automatic report(input string what);
      errors++;
      $display("error at %0t ns: %s", $time, what);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      end
   endtask

   always @(posedge clk) begin
      reset_q    <= reset;
      busy_q     <= mgmt_busy;
      start_ok_q <= lt_start && !mgmt_busy && (tap_to_upd != '0);
   end

   // outputs are compared on the falling edge half a cycle after they change
   always @(negedge clk) begin
      cycle++;
      if (reset_q) begin
         if (av_write || rc_busy)
            report("av_write or rc_busy is high during reset");
         exp_q.delete();
         group_pos    = 0;
         pulse_phase  = 0;
         rc_busy_prev = 1'b0;
      end else begin
         if (pulse_phase == 1 && busy_q) begin
            pulse_phase = 2;
         end else if (pulse_phase == 2 && !busy_q) begin
            pulse_phase = 3;
            fall_cycle  = cycle;           // DUT saw the end of the busy pulse
         end
         if (rc_busy && !rc_busy_prev) begin
            requests++;
            rise_cycle  = cycle;
            first_write = 1'b1;
            if (!start_ok_q)
               report("rc_busy rose without a valid start request");
            expected_writes(tap_to_upd, main_tap, post_tap, pre_tap, logical_channel);
         end
         if (!rc_busy && !rc_busy_prev && start_ok_q)
            report("a valid start request was not accepted");
         if (av_write) begin
            writes++;
            if (exp_q.size() == 0) begin
               report("register write with no write outstanding");
            end else begin
               exp_word = exp_q.pop_front();
               check_value("av_address", exp_word[63:32], av_address);
               check_value("av_writedata", exp_word[31:0], av_writedata);
               if (first_write) begin
                  if (cycle != rise_cycle + 1)
                     report("first write is not two edges after the request was accepted");
               end else if (group_pos == 0) begin
                  if (pulse_phase != 3)
                     report("next tap written before the controller busy pulse ended");
                  else if (cycle != fall_cycle + 1)
                     report("taps are not separated by exactly one idle cycle");
               end else if (cycle != last_write_cycle + 1) begin
                  report("the four writes of a tap are not on consecutive cycles");
               end
               first_write      = 1'b0;
               last_write_cycle = cycle;
               group_pos        = (group_pos + 1) % 4;
               if (group_pos == 0)
                  pulse_phase = 1;         // the status write is out so a busy pulse must follow
            end
         end
         if (!rc_busy && rc_busy_prev) begin
            if (exp_q.size() != 0)
               report($sformatf("rc_busy fell with %0d writes still missing", exp_q.size()));
            else if (pulse_phase != 3 || cycle != fall_cycle)
               report("rc_busy did not fall right after the last busy pulse");
         end
         rc_busy_prev = rc_busy;
      end
   end

endmodule

`default_nettype wire

// File: testbench/pma_reconfig_properties.sv
/* concurrent assertions on the updater bus strobe and busy outputs
   attached to the top level by the bind at the end of this file */
`default_nettype none

module pma_reconfig_properties (
   input wire clk,
   input wire reset,
   input wire mgmt_busy,
   input wire av_write,
   input wire rc_busy
);
   timeunit 1ns;
   timeprecision 100ps;

   // every register write belongs to an accepted request
   write_in_request: assert property (@(posedge clk) disable iff (reset) av_write |-> rc_busy)
      else $error("register write while rc_busy is low");

   no_write_when_busy: assert property (@(posedge clk) disable iff (reset) mgmt_busy |-> !av_write)
      else $error("register write while the controller is busy");   // controller would drop it

   quiet_in_reset: assert property (@(posedge clk) reset |-> !av_write && !rc_busy)
      else $error("av_write or rc_busy high while reset is applied");

endmodule

bind pma_reconfig_top pma_reconfig_properties i_properties (
   .clk       (clk),
   .reset     (reset),
   .mgmt_busy (mgmt_busy),
   .av_write  (av_write),
   .rc_busy   (rc_busy)
);

`default_nettype wire

// File: testbench/tb_pma_reconfig.sv
/* top level testbench of the analog settings updater
   drives directed and random tap requests, models the controller busy pulse and ends the run */
`default_nettype none

module tb_pma_reconfig;
   timeunit 1ns;
   timeprecision 100ps;
   import reconfig_regs_pkg::*;
   import pma_tap_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int RANDOM_REQS  = 24;
   // directed pair, pre-tap sweep, two ignored starts, random requests, one after the second reset
   localparam int PLANNED_REQS = 2 + 16 + 2 + RANDOM_REQS + 1;
   localparam int CYCLE_LIMIT  = PLANNED_REQS * 200 + 2 * RESET_CYCLES;

   logic                      clk = 1'b0;
   logic                      reset;
   logic                      lt_start;
   logic                      force_busy;      // holds the controller busy for the ignored start
   logic                      model_busy;      // busy pulse of the controller model
   wire                       mgmt_busy = model_busy || force_busy;
   logic [TAP_COUNT-1:0]      tap_to_upd;
   logic [MAIN_TAP_WIDTH-1:0] main_tap;
   logic [POST_TAP_WIDTH-1:0] post_tap;
   logic [PRE_TAP_WIDTH-1:0]  pre_tap;
   logic [AV_DATA_WIDTH-1:0]  logical_channel;
   logic                      av_write;
   logic [AV_ADDR_WIDTH-1:0]  av_address;
   logic [AV_DATA_WIDTH-1:0]  av_writedata;
   logic                      rc_busy;
   int                        error_count;
   int                        write_count;
   int                        request_count;
   int                        cycle_count;
   logic [31:0]               stim_seed;       // generator state of the request stimulus
   logic [31:0]               ctrl_seed;       // generator state of the controller model
   logic [1:0]                ctrl_phase;      // 0 idle, 1 start latency, 2 busy
   int                        ctrl_count;

   pma_reconfig_top i_dut (.*);

   pma_reconfig_checker i_checker (.*);

   always #10 clk = ~clk;                      // 20 ns period

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // value in lo..hi taken from the better mixed upper half of the state
   function automatic int pick(input logic [31:0] state, input int lo, input int hi);
      return lo + int'(state[31:16]) % (hi - lo + 1);
   endfunction

   // controller model that raises busy 1 to 4 cycles after a status write for 2 to 8 cycles
   always @(negedge clk) begin
      case (ctrl_phase)
         2'd0: begin
            if (av_write && av_address == ADDR_XR_ANALOG_STATUS) begin
               ctrl_seed  = lcg_step(ctrl_seed);
               ctrl_count = pick(ctrl_seed, 1, 4);
               ctrl_phase = 2'd1;
            end
         end
         2'd1: begin
            ctrl_count = ctrl_count - 1;
            if (ctrl_count == 0) begin
               model_busy = 1'b1;
               ctrl_seed  = lcg_step(ctrl_seed);
               ctrl_count = pick(ctrl_seed, 2, 8);
               ctrl_phase = 2'd2;
            end
         end
         default: begin
            ctrl_count = ctrl_count - 1;
            if (ctrl_count == 0) begin
               model_busy = 1'b0;
               ctrl_phase = 2'd0;
            end
         end
      endcase
   end

   task automatic apply_reset();
      reset = 1'b1;                            // called at time zero or on a falling edge
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
   endtask

   // one link training request whose values stay put until rc_busy has fallen
   task automatic run_request(input logic [TAP_COUNT-1:0]     mask,
                              input logic [PRE_TAP_WIDTH-1:0] pre);
      @(negedge clk);
      stim_seed       = lcg_step(stim_seed);
      main_tap        = stim_seed[21:16];
      post_tap        = stim_seed[28:24];
      logical_channel = lcg_step(stim_seed);
      pre_tap         = pre;
      tap_to_upd      = mask;
      lt_start        = 1'b1;
      if (mask == '0) begin
         repeat (4) @(negedge clk);            // an empty mask has to be ignored
      end else begin
         @(negedge clk);
         while (!rc_busy) @(negedge clk);
         lt_start = 1'b0;
         while (rc_busy) @(negedge clk);
      end
      lt_start  = 1'b0;
      stim_seed = lcg_step(stim_seed);
      repeat (pick(stim_seed, 1, 6)) @(negedge clk);
   endtask

   // start held while the controller reports busy
   task automatic busy_start();
      @(negedge clk);
      force_busy = 1'b1;
      tap_to_upd = 3'b111;
      lt_start   = 1'b1;
      repeat (6) @(negedge clk);
      lt_start = 1'b0;
      @(negedge clk);
      force_busy = 1'b0;
   endtask

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      int v;
      lt_start        = 1'b0;
      force_busy      = 1'b0;
      model_busy      = 1'b0;
      ctrl_phase      = 2'd0;
      ctrl_count      = 0;
      tap_to_upd      = '0;
      main_tap        = '0;
      post_tap        = '0;
      pre_tap         = '0;
      logical_channel = '0;
      cycle_count     = 0;
      stim_seed       = 32'hc014ce0e;
      ctrl_seed       = ~32'hc014ce0e;
      apply_reset();
      run_request(3'b100, 4'd0);               // main tap only
      run_request(3'b111, 4'd5);               // all three taps
      for (v = 0; v < 16; v++) begin
         stim_seed = lcg_step(stim_seed);
         run_request(stim_seed[18:16] | 3'b001, v[3:0]);   // every pre-tap value
      end
      run_request(3'b000, 4'd3);
      busy_start();
      repeat (RANDOM_REQS) begin
         stim_seed = lcg_step(stim_seed);
         run_request(stim_seed[18:16], stim_seed[23:20]);
      end
      apply_reset();
      run_request(3'b100, 4'd9);               // first request after a second reset
      repeat (4) @(negedge clk);
      $display("requests %0d, writes %0d, errors %0d", request_count, write_count, error_count);
      if (error_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: pma_reconfig.f
source/reconfig_regs_pkg.sv
source/pma_tap_pkg.sv
source/tap_request_queue.sv
source/tap_word_encoder.sv
source/analog_write_sequencer.sv
source/pma_reconfig_top.sv
testbench/pma_reconfig_checker.sv
testbench/pma_reconfig_properties.sv
testbench/tb_pma_reconfig.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_pma_reconfig -f pma_reconfig.f
output=$(./obj_dir/Vtb_pma_reconfig 2>&1 || true)
echo "$output"
if echo "$output" | grep -qx "TEST OK"; then
   exit 0
fi
exit 1
